// ==== src/gat_pkg.sv ====
package gat_pkg;

  //////////////////////////////////////////////////
  // datapath sizes
  //////////////////////////////////////////////////

  // nodes per graph.
  localparam int unsigned N_NODES = 16;

  // node address width.
  localparam int unsigned NODE_AW = 4;

  //////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////

  typedef logic signed [15:0] feat_t;
  typedef logic signed [15:0] wgt_t;

  // feature times weight.
  typedef logic signed [31:0] wh_t;

  // 4 guard bits, enough for 16 products.
  typedef logic signed [35:0] acc_t;

endpackage

// ==== src/dbg_pkg.sv ====
package dbg_pkg;

  // node whose product is latched.
  localparam int unsigned CAP_ADDR = 5;

  localparam int unsigned RUN_CNT_W = 16;

  //////////////////////////////////////////////////
  // flag word layout
  //////////////////////////////////////////////////

  typedef logic [7:0] dbg_flags_t;

  localparam int unsigned FLG_LOAD     = 0;
  localparam int unsigned FLG_WR_BUSY  = 1;
  localparam int unsigned FLG_SC_START = 2;
  localparam int unsigned FLG_SC_DONE  = 3;
  localparam int unsigned FLG_AG_START = 4;
  localparam int unsigned FLG_AG_DONE  = 5;
  // bits 6 and 7 unused, read as zero.

endpackage

// ==== src/stage_bus_if.sv ====
`timescale 1ns/10ps

interface stage_bus_if;

  // one-cycle strobes.
  logic sc_start;
  logic sc_done;
  logic ag_start;
  logic ag_done;

  // level, high while a run is in progress.
  logic busy;

  modport ctrl (
    output sc_start,
    output ag_start,
    output busy,
    input  sc_done,
    input  ag_done
  );

  modport scale (
    input  sc_start,
    output sc_done
  );

  modport aggr (
    input  ag_start,
    output ag_done
  );

  modport mon (
    input  sc_start,
    input  sc_done,
    input  ag_start,
    input  ag_done,
    input  busy
  );

endinterface

// ==== src/bram_sdp.sv ====
`timescale 1ns/10ps

module bram_sdp #(
  parameter type T = gat_pkg::feat_t
) (
  input  logic                        clk,
  input  logic                        we_i,
  input  logic [gat_pkg::NODE_AW-1:0] waddr_i,
  input  T                            wdata_i,
  input  logic                        re_i,
  input  logic [gat_pkg::NODE_AW-1:0] raddr_i,
  output T                            rdata_o
);

  import gat_pkg::*;

  T mem [N_NODES];

  // write port.
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read port, one cycle of latency.
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// ==== src/sched_ctrl.sv ====
`timescale 1ns/10ps

module sched_ctrl (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start_i,
  stage_bus_if.ctrl    bus,
  output logic         done_o
);

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SCALE  = 2'd1,
    ST_AGGR   = 2'd2,
    ST_FINISH = 2'd3
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   sc_start_q;
  logic   sc_start_d;
  logic   ag_start_q;
  logic   ag_start_d;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    sc_start_d = 1'b0;
    ag_start_d = 1'b0;
    case (state_q)
      // finish is the closing cycle; busy is already low there.
      ST_IDLE, ST_FINISH: begin
        if (start_i) begin
          state_d    = ST_SCALE;
          sc_start_d = 1'b1;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_SCALE: begin
        if (bus.sc_done) begin
          state_d    = ST_AGGR;
          ag_start_d = 1'b1;
        end
      end
      ST_AGGR: begin
        if (bus.ag_done) begin
          state_d = ST_FINISH;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      sc_start_q <= 1'b0;
      ag_start_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      sc_start_q <= sc_start_d;
      ag_start_q <= ag_start_d;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign bus.sc_start = sc_start_q;
  assign bus.ag_start = ag_start_q;
  assign bus.busy     = (state_q == ST_SCALE) || (state_q == ST_AGGR);

  // run ends with the aggregation strobe.
  assign done_o = (state_q == ST_AGGR) && bus.ag_done;

endmodule

// ==== src/scale_unit.sv ====
`timescale 1ns/10ps

module scale_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  stage_bus_if.scale                  bus,
  input  gat_pkg::wgt_t               wgt_i,
  output logic                        feat_re_o,
  output logic [gat_pkg::NODE_AW-1:0] feat_raddr_o,
  input  gat_pkg::feat_t              feat_rdata_i,
  output logic                        wh_we_o,
  output logic [gat_pkg::NODE_AW-1:0] wh_addr_o,
  output gat_pkg::wh_t                wh_data_o
);

  import gat_pkg::*;

  logic               rd_active;
  logic [NODE_AW-1:0] rd_cnt;
  logic               rvld_q;
  logic [NODE_AW-1:0] raddr_q;
  logic               sc_done_q;

  //////////////////////////////////////////////////
  // read issue
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      rd_cnt    <= '0;
    end else if (bus.sc_start) begin
      rd_active <= 1'b1;
      rd_cnt    <= '0;
    end else if (rd_active) begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_cnt == NODE_AW'(N_NODES - 1)) begin
        rd_active <= 1'b0;
      end
    end
  end

  assign feat_re_o    = rd_active;
  assign feat_raddr_o = rd_cnt;

  // address follows the memory latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvld_q    <= 1'b0;
      wh_we_o   <= 1'b0;
      sc_done_q <= 1'b0;
    end else begin
      rvld_q    <= rd_active;
      wh_we_o   <= rvld_q;
      sc_done_q <= rvld_q && (raddr_q == NODE_AW'(N_NODES - 1));
    end
  end

  always_ff @(posedge clk) begin
    raddr_q   <= rd_cnt;
    wh_addr_o <= raddr_q;
    wh_data_o <= wh_t'(feat_rdata_i) * wh_t'(wgt_i);
  end

  assign bus.sc_done = sc_done_q;

endmodule

// ==== src/aggr_unit.sv ====
`timescale 1ns/10ps

module aggr_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  stage_bus_if.aggr                   bus,
  output logic                        wh_re_o,
  output logic [gat_pkg::NODE_AW-1:0] wh_raddr_o,
  input  gat_pkg::wh_t                wh_rdata_i,
  output gat_pkg::acc_t               sum_o,
  output gat_pkg::wh_t                max_o
);

  import gat_pkg::*;

  logic               rd_active;
  logic [NODE_AW-1:0] rd_cnt;
  logic               rvld_q;
  logic [NODE_AW-1:0] raddr_q;
  logic               first;
  logic               last;
  acc_t               sum_q;
  acc_t               sum_nxt;
  wh_t                max_q;
  wh_t                max_nxt;
  logic               ag_done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      rd_cnt    <= '0;
    end else if (bus.ag_start) begin
      rd_active <= 1'b1;
      rd_cnt    <= '0;
    end else if (rd_active) begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_cnt == NODE_AW'(N_NODES - 1)) begin
        rd_active <= 1'b0;
      end
    end
  end

  assign wh_re_o    = rd_active;
  assign wh_raddr_o = rd_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvld_q <= 1'b0;
    end else begin
      rvld_q <= rd_active;
    end
  end

  always_ff @(posedge clk) begin
    raddr_q <= rd_cnt;
  end

  //////////////////////////////////////////////////
  // accumulate
  //////////////////////////////////////////////////

  assign first = (raddr_q == '0);
  assign last  = (raddr_q == NODE_AW'(N_NODES - 1));

  // first product seeds both sum and max.
  assign sum_nxt = first ? acc_t'(wh_rdata_i) : sum_q + acc_t'(wh_rdata_i);
  assign max_nxt = (first || (wh_rdata_i > max_q)) ? wh_rdata_i : max_q;

  always_ff @(posedge clk) begin
    if (rvld_q) begin
      sum_q <= sum_nxt;
      max_q <= max_nxt;
    end
  end

  // results update together with done.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_o     <= '0;
      max_o     <= '0;
      ag_done_q <= 1'b0;
    end else begin
      ag_done_q <= rvld_q && last;
      if (rvld_q && last) begin
        sum_o <= sum_nxt;
        max_o <= max_nxt;
      end
    end
  end

  assign bus.ag_done = ag_done_q;

endmodule

// ==== src/debugger.sv ====
`timescale 1ns/10ps

module debugger (
  input  logic                          clk,
  input  logic                          rst_n,
  stage_bus_if.mon                      bus,
  input  logic                          feat_we_i,
  input  logic                          wh_we_i,
  input  logic [gat_pkg::NODE_AW-1:0]   wh_addr_i,
  input  gat_pkg::wh_t                  wh_data_i,
  output dbg_pkg::dbg_flags_t           flags_o,
  output logic [dbg_pkg::RUN_CNT_W-1:0] runs_o,
  output gat_pkg::wh_t                  cap_o
);

  import gat_pkg::*;
  import dbg_pkg::*;

  dbg_flags_t           events;
  dbg_flags_t           flags_q;
  logic [RUN_CNT_W-1:0] runs_q;
  wh_t                  cap_q;
  logic                 cap_hit;

  //////////////////////////////////////////////////
  // sticky flags
  //////////////////////////////////////////////////

  always_comb begin
    events               = '0;
    events[FLG_LOAD]     = feat_we_i;
    events[FLG_WR_BUSY]  = feat_we_i && bus.busy;
    events[FLG_SC_START] = bus.sc_start;
    events[FLG_SC_DONE]  = bus.sc_done;
    events[FLG_AG_START] = bus.ag_start;
    events[FLG_AG_DONE]  = bus.ag_done;
  end

  // once set, held until reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_q | events;
    end
  end

  //////////////////////////////////////////////////
  // run count and capture
  //////////////////////////////////////////////////

  assign cap_hit = wh_we_i && (wh_addr_i == NODE_AW'(CAP_ADDR));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      runs_q <= '0;
      cap_q  <= '0;
    end else begin
      if (bus.sc_start) begin
        runs_q <= runs_q + 1'b1;
      end
      if (cap_hit) begin
        cap_q <= wh_data_i;
      end
    end
  end

  assign flags_o = flags_q;
  assign runs_o  = runs_q;
  assign cap_o   = cap_q;

endmodule

// ==== src/gat_core.sv ====
`timescale 1ns/10ps

module gat_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  gat_pkg::wgt_t                 wgt_i,
  input  logic                          feat_we_i,
  input  logic [gat_pkg::NODE_AW-1:0]   feat_addr_i,
  input  gat_pkg::feat_t                feat_data_i,
  output logic                          busy_o,
  output logic                          done_o,
  output gat_pkg::acc_t                 sum_o,
  output gat_pkg::wh_t                  max_o,
  output dbg_pkg::dbg_flags_t           dbg_flags_o,
  output logic [dbg_pkg::RUN_CNT_W-1:0] dbg_runs_o,
  output gat_pkg::wh_t                  dbg_cap_o
);

  import gat_pkg::*;

  logic               feat_re;
  logic [NODE_AW-1:0] feat_raddr;
  feat_t              feat_rdata;
  logic               wh_we;
  logic [NODE_AW-1:0] wh_addr;
  wh_t                wh_data;
  logic               wh_re;
  logic [NODE_AW-1:0] wh_raddr;
  wh_t                wh_rdata;

  stage_bus_if u_bus ();

  sched_ctrl u_sched_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .bus     (u_bus.ctrl),
    .done_o  (done_o)
  );

  assign busy_o = u_bus.busy;

  //////////////////////////////////////////////////
  // memories
  //////////////////////////////////////////////////

  bram_sdp #(.T(feat_t)) u_feat_mem (
    .clk     (clk),
    .we_i    (feat_we_i),
    .waddr_i (feat_addr_i),
    .wdata_i (feat_data_i),
    .re_i    (feat_re),
    .raddr_i (feat_raddr),
    .rdata_o (feat_rdata)
  );

  bram_sdp #(.T(wh_t)) u_wh_mem (
    .clk     (clk),
    .we_i    (wh_we),
    .waddr_i (wh_addr),
    .wdata_i (wh_data),
    .re_i    (wh_re),
    .raddr_i (wh_raddr),
    .rdata_o (wh_rdata)
  );

  //////////////////////////////////////////////////
  // stages and debug
  //////////////////////////////////////////////////

  scale_unit u_scale_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (u_bus.scale),
    .wgt_i        (wgt_i),
    .feat_re_o    (feat_re),
    .feat_raddr_o (feat_raddr),
    .feat_rdata_i (feat_rdata),
    .wh_we_o      (wh_we),
    .wh_addr_o    (wh_addr),
    .wh_data_o    (wh_data)
  );

  aggr_unit u_aggr_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (u_bus.aggr),
    .wh_re_o    (wh_re),
    .wh_raddr_o (wh_raddr),
    .wh_rdata_i (wh_rdata),
    .sum_o      (sum_o),
    .max_o      (max_o)
  );

  debugger u_debugger (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (u_bus.mon),
    .feat_we_i (feat_we_i),
    .wh_we_i   (wh_we),
    .wh_addr_i (wh_addr),
    .wh_data_i (wh_data),
    .flags_o   (dbg_flags_o),
    .runs_o    (dbg_runs_o),
    .cap_o     (dbg_cap_o)
  );

endmodule

// ==== tests/clk_rst_gen.sv ====
`timescale 1ns/10ps

module clk_rst_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period.
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  // reset held low for the first 10 cycles.
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== tests/gat_core_props.sv ====
`timescale 1ns/10ps

module gat_core_props (
  input logic clk,
  input logic rst_n,
  input logic busy_i,
  input logic done_i
);

  //////////////////////////////////////////////////
  // done and busy protocol
  //////////////////////////////////////////////////

  // done is a one-cycle strobe.
  done_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) done_i |=> !done_i
  ) else $error("done_o stayed high for more than one cycle");

  // busy drops right after the done cycle.
  busy_low_after_done: assert property (
    @(posedge clk) disable iff (!rst_n) done_i |=> !busy_i
  ) else $error("busy_o still high after the done_o pulse");

  busy_falls_only_on_done: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(busy_i) |-> $past(done_i)
  ) else $error("busy_o fell without a done_o pulse");

  // no done outside a run.
  done_needs_busy: assert property (
    @(posedge clk) disable iff (!rst_n) done_i |-> busy_i
  ) else $error("done_o pulsed while busy_o was low");

endmodule

// ==== tests/tb_gat_core.sv ====
`timescale 1ns/10ps

module tb_gat_core;

  import gat_pkg::*;
  import dbg_pkg::*;

  localparam int RUN_CYCLES  = 2 * N_NODES + 6;
  localparam int CYCLE_LIMIT = 4 * RUN_CYCLES + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 start_i;
  wgt_t                 wgt_i;
  logic                 feat_we_i;
  logic [NODE_AW-1:0]   feat_addr_i;
  feat_t                feat_data_i;
  logic                 busy_o;
  logic                 done_o;
  acc_t                 sum_o;
  wh_t                  max_o;
  dbg_flags_t           dbg_flags_o;
  logic [RUN_CNT_W-1:0] dbg_runs_o;
  wh_t                  dbg_cap_o;

  integer seed = 32'h93f3577e;
  feat_t  feat [N_NODES];
  int     cycle_cnt = 0;
  int     done_cnt = 0;

  clk_rst_gen u_clk_rst_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_core dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .wgt_i       (wgt_i),
    .feat_we_i   (feat_we_i),
    .feat_addr_i (feat_addr_i),
    .feat_data_i (feat_data_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .sum_o       (sum_o),
    .max_o       (max_o),
    .dbg_flags_o (dbg_flags_o),
    .dbg_runs_o  (dbg_runs_o),
    .dbg_cap_o   (dbg_cap_o)
  );

  bind gat_core gat_core_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy_i (busy_o),
    .done_i (done_o)
  );

  //////////////////////////////////////////////////
  // run limit and done counting
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (done_o === 1'b1) begin
      done_cnt <= done_cnt + 1;
    end
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: no end of test after %0d cycles", cycle_cnt);
      $display("sim failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input bit ok, input string what);
    assert (ok) else begin
      $display("mismatch at %0t: %s", $time, what);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic write_feature(input int k, input feat_t d);
    @(posedge clk);
    feat_we_i   <= 1'b1;
    feat_addr_i <= NODE_AW'(k);
    feat_data_i <= d;
    @(posedge clk);
    feat_we_i <= 1'b0;
  endtask

  task automatic start_run(input wgt_t w);
    @(posedge clk);
    wgt_i   <= w;
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  // returns at the falling edge inside the done cycle.
  task automatic wait_done;
    @(negedge clk);
    while (done_o !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_busy;
    while (busy_o !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  function automatic dbg_flags_t flags_after_run(input logic wr_busy);
    dbg_flags_t f;
    f               = '0;
    f[FLG_LOAD]     = 1'b1;
    f[FLG_WR_BUSY]  = wr_busy;
    f[FLG_SC_START] = 1'b1;
    f[FLG_SC_DONE]  = 1'b1;
    f[FLG_AG_START] = 1'b1;
    f[FLG_AG_DONE]  = 1'b1;
    return f;
  endfunction

  // reference model of sum and max over feat times weight.
  task automatic check_results(input wgt_t w);
    longint prod;
    longint exp_sum;
    longint exp_max;
    longint exp_cap;
    exp_sum = 0;
    exp_max = 0;
    for (int k = 0; k < N_NODES; k++) begin
      prod = longint'(feat[NODE_AW'(k)]) * longint'(w);
      exp_sum += prod;
      if (k == 0 || prod > exp_max) begin
        exp_max = prod;
      end
    end
    exp_cap = longint'(feat[NODE_AW'(CAP_ADDR)]) * longint'(w);
    check_value(longint'(sum_o) == exp_sum,
                $sformatf("sum_o %0d, expected %0d", sum_o, exp_sum));
    check_value(longint'(max_o) == exp_max,
                $sformatf("max_o %0d, expected %0d", max_o, exp_max));
    check_value(longint'(dbg_cap_o) == exp_cap,
                $sformatf("dbg_cap_o %0d, expected %0d", dbg_cap_o, exp_cap));
  endtask

  // debug state and idle check one cycle after done.
  task automatic check_after_run(input int runs, input logic wr_busy);
    @(negedge clk);
    check_value(busy_o == 1'b0, "busy_o high after the run ended");
    check_value(done_cnt == runs, $sformatf("done count %0d, expected %0d", done_cnt, runs));
    check_value(dbg_runs_o == RUN_CNT_W'(runs),
                $sformatf("dbg_runs_o %0d, expected %0d", dbg_runs_o, runs));
    check_value(dbg_flags_o == flags_after_run(wr_busy),
                $sformatf("dbg_flags_o %b, expected %b", dbg_flags_o,
                          flags_after_run(wr_busy)));
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    wgt_t        w;
    start_i     = 1'b0;
    wgt_i       = '0;
    feat_we_i   = 1'b0;
    feat_addr_i = '0;
    feat_data_i = '0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value(busy_o == 1'b0 && done_o == 1'b0, "busy_o or done_o high after reset");
    check_value(sum_o == '0 && max_o == '0, "sum_o or max_o not zero after reset");
    check_value(dbg_flags_o == '0 && dbg_runs_o == '0 && dbg_cap_o == '0,
                "debug state not zero after reset");

    for (int k = 0; k < N_NODES; k++) begin
      rnd = $random(seed);
      feat[NODE_AW'(k)] = rnd[15:0];
      write_feature(k, rnd[15:0]);
    end

    // plain run.
    rnd = $random(seed);
    w = rnd[15:0];
    start_run(w);
    wait_done();
    check_results(w);
    check_after_run(1, 1'b0);

    // a second start while busy is dropped.
    rnd = $random(seed);
    w = rnd[15:0];
    start_run(w);
    wait_busy();
    start_run(w);
    wait_done();
    check_results(w);
    check_after_run(2, 1'b0);

    // feature write during the run with the same data.
    rnd = $random(seed);
    w = rnd[15:0];
    start_run(w);
    wait_busy();
    write_feature(0, feat[0]);
    wait_done();
    check_results(w);
    check_after_run(3, 1'b1);

    // negative weight.
    rnd = $random(seed);
    w = {1'b1, rnd[14:0]};
    start_run(w);
    wait_done();
    check_results(w);
    check_after_run(4, 1'b1);

    $display("sim passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/gat_pkg.sv
src/dbg_pkg.sv
src/stage_bus_if.sv
src/bram_sdp.sv
src/sched_ctrl.sv
src/scale_unit.sv
src/aggr_unit.sv
src/debugger.sv
src/gat_core.sv
tests/clk_rst_gen.sv
tests/gat_core_props.sv
tests/tb_gat_core.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_gat_core \
  -f vlog.f \
  -o sim_gat_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_gat_core
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit 1
fi
exit 0
